// ==== Makefile ====
# Verilator build and run of the board I/O testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check sim.log for the pass line"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --top-module board_io_tb \
		-Mdir obj_dir -o board_io_sim -f compile.f
	./obj_dir/board_io_sim | tee sim.log
	@grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
logic/board_pkg.sv
logic/input_sync.sv
logic/i2c_port.sv
logic/bpi_flash_port.sv
logic/reboot_sequencer.sv
logic/board_io_top.sv
verif/board_io_tb.sv

// ==== logic/board_io_top.sv ====
// Single clock domain; bidirectional pins come out as value, enable and raw input for the pad level
`timescale 1ns/10ps

module board_io_top #(
    parameter int SYNC_STAGES = board_pkg::SYNC_STAGES
) (
    input  logic                                pcie_user_clk,
    input  logic                                reset_i,

    input  logic [board_pkg::I2C_LINE_COUNT-1:0]  i2c_drive_i,
    input  logic [board_pkg::I2C_LINE_COUNT-1:0]  i2c_release_i,
    input  logic [board_pkg::I2C_LINE_COUNT-1:0]  i2c_pin_i,
    output logic [board_pkg::I2C_LINE_COUNT-1:0]  i2c_drive_o,
    output logic [board_pkg::I2C_LINE_COUNT-1:0]  i2c_release_o,
    output logic [board_pkg::I2C_LINE_COUNT-1:0]  i2c_sync_o,

    input  logic [board_pkg::FLASH_ADDR_W-1:0]    flash_addr_i,
    output logic [board_pkg::FLASH_ADDR_W-1:0]    flash_addr_o,
    input  logic [board_pkg::FLASH_DQ_W-1:0]      flash_dq_i,
    output logic [board_pkg::FLASH_DQ_W-1:0]      flash_dq_o,
    input  logic                                flash_dq_oe_i,
    output logic                                flash_dq_oe_o,
    input  logic                                flash_region_i,
    output logic                                flash_region_o,
    input  logic                                flash_region_oe_i,
    output logic                                flash_region_oe_o,
    input  logic                                flash_ce_n_i,
    input  logic                                flash_oe_n_i,
    input  logic                                flash_we_n_i,
    input  logic                                flash_adv_n_i,
    output logic                                flash_ce_n_o,
    output logic                                flash_oe_n_o,
    output logic                                flash_we_n_o,
    output logic                                flash_adv_n_o,
    input  logic [board_pkg::FLASH_DQ_W-1:0]      flash_dq_pin_i,
    output logic [board_pkg::FLASH_DQ_W-1:0]      flash_dq_sync_o,

    input  logic                                fpga_boot_i,
    input  logic                                icap_avail_i,
    output logic                                icap_csib_o,
    output logic                                icap_rdwrb_o,
    output logic [board_pkg::ICAP_W-1:0]          icap_data_o,

    input  logic [board_pkg::STATUS_IN_COUNT-1:0] sfp_status_pin_i,
    output logic [board_pkg::STATUS_IN_COUNT-1:0] sfp_status_sync_o,
    input  logic [board_pkg::SFP_COUNT-1:0]       sfp_rx_status_i,
    output logic [board_pkg::SFP_COUNT-1:0]       sfp_led_o
);

    // Presence and loss-of-signal from the cages
    input_sync #(
        .WIDTH(board_pkg::STATUS_IN_COUNT),
        .STAGES(SYNC_STAGES)
    ) status_sync_inst (
        .pcie_user_clk(pcie_user_clk),
        .reset_i(reset_i),
        .in_i(sfp_status_pin_i),
        .out_o(sfp_status_sync_o)
    );

    i2c_port #(
        .SYNC_STAGES(SYNC_STAGES)
    ) i2c_port_inst (
        .pcie_user_clk(pcie_user_clk),
        .reset_i(reset_i),
        .i2c_drive_i(i2c_drive_i),
        .i2c_release_i(i2c_release_i),
        .i2c_pin_i(i2c_pin_i),
        .i2c_drive_o(i2c_drive_o),
        .i2c_release_o(i2c_release_o),
        .i2c_sync_o(i2c_sync_o)
    );

    bpi_flash_port #(
        .SYNC_STAGES(SYNC_STAGES)
    ) flash_port_inst (
        .pcie_user_clk(pcie_user_clk),
        .reset_i(reset_i),
        .flash_addr_i(flash_addr_i),
        .flash_addr_o(flash_addr_o),
        .flash_dq_i(flash_dq_i),
        .flash_dq_o(flash_dq_o),
        .flash_dq_oe_i(flash_dq_oe_i),
        .flash_dq_oe_o(flash_dq_oe_o),
        .flash_region_i(flash_region_i),
        .flash_region_o(flash_region_o),
        .flash_region_oe_i(flash_region_oe_i),
        .flash_region_oe_o(flash_region_oe_o),
        .flash_ce_n_i(flash_ce_n_i),
        .flash_oe_n_i(flash_oe_n_i),
        .flash_we_n_i(flash_we_n_i),
        .flash_adv_n_i(flash_adv_n_i),
        .flash_ce_n_o(flash_ce_n_o),
        .flash_oe_n_o(flash_oe_n_o),
        .flash_we_n_o(flash_we_n_o),
        .flash_adv_n_o(flash_adv_n_o),
        .flash_dq_pin_i(flash_dq_pin_i),
        .flash_dq_sync_o(flash_dq_sync_o)
    );

    reboot_sequencer reboot_inst (
        .pcie_user_clk(pcie_user_clk),
        .reset_i(reset_i),
        .fpga_boot_i(fpga_boot_i),
        .icap_avail_i(icap_avail_i),
        .icap_csib_o(icap_csib_o),
        .icap_rdwrb_o(icap_rdwrb_o),
        .icap_data_o(icap_data_o)
    );

    // Link LED per cage, lit with the PHY rx status
    assign sfp_led_o = sfp_rx_status_i;

endmodule

// ==== logic/board_pkg.sv ====
// Shared widths, counts and encodings for the board I/O glue; ICAP words are stored un-reversed
package board_pkg;

    // Default depth for the slow-input synchronizers
    localparam int SYNC_STAGES = 2;

    // BPI configuration flash
    localparam int FLASH_DQ_W = 16;
    localparam int FLASH_ADDR_W = 23;

    // Bit order: cage scl, cage 1 sda, cage 2 sda, eeprom scl, eeprom sda
    localparam int I2C_LINE_COUNT = 5;

    // Bit order: npres 1, npres 2, los 1, los 2
    localparam int STATUS_IN_COUNT = 4;
    localparam int SFP_COUNT = 2;

    localparam int ICAP_W = 32;

    typedef enum logic [2:0] {
        RB_IDLE,
        RB_SYNC,
        RB_NOOP,
        RB_CMD,
        RB_IPROG,
        RB_TAIL
    } reboot_state_t;

    // Configuration commands as written in the bitstream
    typedef enum logic [ICAP_W-1:0] {
        ICAP_DUMMY     = 32'hFFFF_FFFF,
        ICAP_SYNC      = 32'hAA99_5566,
        ICAP_NOOP      = 32'h2000_0000,
        // Type 1 write, one word, command register
        ICAP_WRITE_CMD = 32'h3000_8001,
        ICAP_IPROG     = 32'h0000_000F
    } icap_word_t;

endpackage

// ==== logic/bpi_flash_port.sv ====
// Core must never request oe_n and we_n low together, nor drive dq while the flash drives it
`timescale 1ns/10ps

module bpi_flash_port #(
    parameter int SYNC_STAGES = board_pkg::SYNC_STAGES
) (
    input  logic                             pcie_user_clk,
    input  logic                             reset_i,
    input  logic [board_pkg::FLASH_ADDR_W-1:0] flash_addr_i,
    output logic [board_pkg::FLASH_ADDR_W-1:0] flash_addr_o,
    input  logic [board_pkg::FLASH_DQ_W-1:0]   flash_dq_i,
    output logic [board_pkg::FLASH_DQ_W-1:0]   flash_dq_o,
    input  logic                             flash_dq_oe_i,
    output logic                             flash_dq_oe_o,
    input  logic                             flash_region_i,
    output logic                             flash_region_o,
    input  logic                             flash_region_oe_i,
    output logic                             flash_region_oe_o,
    input  logic                             flash_ce_n_i,
    input  logic                             flash_oe_n_i,
    input  logic                             flash_we_n_i,
    input  logic                             flash_adv_n_i,
    output logic                             flash_ce_n_o,
    output logic                             flash_oe_n_o,
    output logic                             flash_we_n_o,
    output logic                             flash_adv_n_o,
    input  logic [board_pkg::FLASH_DQ_W-1:0]   flash_dq_pin_i,
    output logic [board_pkg::FLASH_DQ_W-1:0]   flash_dq_sync_o
);

    always_ff @(posedge pcie_user_clk) begin
        if (reset_i) begin
            // Device deselected, bus released
            flash_ce_n_o <= 1'b1;
            flash_oe_n_o <= 1'b1;
            flash_we_n_o <= 1'b1;
            flash_adv_n_o <= 1'b1;
            flash_dq_oe_o <= 1'b0;
            flash_region_oe_o <= 1'b0;
            flash_addr_o <= '0;
            flash_dq_o <= '0;
            flash_region_o <= 1'b0;
        end else begin
            flash_ce_n_o <= flash_ce_n_i;
            flash_oe_n_o <= flash_oe_n_i;
            flash_we_n_o <= flash_we_n_i;
            flash_adv_n_o <= flash_adv_n_i;
            flash_dq_oe_o <= flash_dq_oe_i;
            flash_region_oe_o <= flash_region_oe_i;
            flash_addr_o <= flash_addr_i;
            flash_dq_o <= flash_dq_i;
            flash_region_o <= flash_region_i;
        end
    end

    input_sync #(
        .WIDTH(board_pkg::FLASH_DQ_W),
        .STAGES(SYNC_STAGES)
    ) dq_sync_inst (
        .pcie_user_clk(pcie_user_clk),
        .reset_i(reset_i),
        .in_i(flash_dq_pin_i),
        .out_o(flash_dq_sync_o)
    );

    a_no_read_write: assert property (
        @(posedge pcie_user_clk) disable iff (reset_i) !(!flash_oe_n_o && !flash_we_n_o)
    ) else $error("flash oe_n and we_n both asserted");

    // Bus contention with the flash output drivers
    a_no_dq_contention: assert property (
        @(posedge pcie_user_clk) disable iff (reset_i) !(flash_dq_oe_o && !flash_oe_n_o)
    ) else $error("flash dq driven during a read");

endmodule

// ==== logic/i2c_port.sv ====
// Open-drain lines: the board top must drive low only when release is 0; pull-ups are external
`timescale 1ns/10ps

module i2c_port #(
    parameter int SYNC_STAGES = board_pkg::SYNC_STAGES
) (
    input  logic                               pcie_user_clk,
    input  logic                               reset_i,
    input  logic [board_pkg::I2C_LINE_COUNT-1:0] i2c_drive_i,
    input  logic [board_pkg::I2C_LINE_COUNT-1:0] i2c_release_i,
    input  logic [board_pkg::I2C_LINE_COUNT-1:0] i2c_pin_i,
    output logic [board_pkg::I2C_LINE_COUNT-1:0] i2c_drive_o,
    output logic [board_pkg::I2C_LINE_COUNT-1:0] i2c_release_o,
    output logic [board_pkg::I2C_LINE_COUNT-1:0] i2c_sync_o
);

    // Pad-side register so the lines only change on a clock edge
    always_ff @(posedge pcie_user_clk) begin
        if (reset_i) begin
            i2c_drive_o <= '1;
            i2c_release_o <= '1;
        end else begin
            i2c_drive_o <= i2c_drive_i;
            i2c_release_o <= i2c_release_i;
        end
    end

    // Line readback for clock stretching and arbitration
    input_sync #(
        .WIDTH(board_pkg::I2C_LINE_COUNT),
        .STAGES(SYNC_STAGES)
    ) pin_sync_inst (
        .pcie_user_clk(pcie_user_clk),
        .reset_i(reset_i),
        .in_i(i2c_pin_i),
        .out_o(i2c_sync_o)
    );

    // Every line floats on the first cycle out of reset
    a_released_after_reset: assert property (
        @(posedge pcie_user_clk) $past(reset_i) |-> &i2c_release_o
    ) else $error("I2C line driven right after reset");

endmodule

// ==== logic/input_sync.sv ====
// Level inputs only: pulses shorter than a clock period or multi-bit buses with skew are not safe
`timescale 1ns/10ps

module input_sync #(
    parameter int WIDTH = 1,
    parameter int STAGES = 2
) (
    input  logic             pcie_user_clk,
    input  logic             reset_i,
    input  logic [WIDTH-1:0] in_i,
    output logic [WIDTH-1:0] out_o
);

    logic [WIDTH-1:0] sync_q [STAGES];

    always_ff @(posedge pcie_user_clk) begin
        if (reset_i) begin
            for (int i = 0; i < STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= in_i;
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i - 1];
            end
        end
    end

    assign out_o = sync_q[STAGES - 1];

    // A single rank gives no settling time for metastability
    a_min_stages: assert property (@(posedge pcie_user_clk) STAGES >= 2)
        else $error("input_sync needs at least two stages");

endmodule

// ==== logic/reboot_sequencer.sv ====
// avail is checked only at start; a running sequence is never stalled; write-only port
`timescale 1ns/10ps

module reboot_sequencer (
    input  logic                       pcie_user_clk,
    input  logic                       reset_i,
    input  logic                       fpga_boot_i,
    input  logic                       icap_avail_i,
    output logic                       icap_csib_o,
    output logic                       icap_rdwrb_o,
    output logic [board_pkg::ICAP_W-1:0] icap_data_o
);

    board_pkg::reboot_state_t state_q;
    board_pkg::icap_word_t word_q;
    logic start_seq;

    // csib still low means the tail word is on the port, so leave one idle cycle
    assign start_seq = fpga_boot_i && icap_avail_i && icap_csib_o;

    always_ff @(posedge pcie_user_clk) begin
        if (reset_i) begin
            state_q <= board_pkg::RB_IDLE;
            icap_csib_o <= 1'b1;
            word_q <= board_pkg::ICAP_DUMMY;
        end else begin
            icap_csib_o <= 1'b0;
            case (state_q)
                board_pkg::RB_IDLE: begin
                    word_q <= board_pkg::ICAP_DUMMY;
                    if (start_seq) begin
                        state_q <= board_pkg::RB_SYNC;
                    end else begin
                        icap_csib_o <= 1'b1;
                    end
                end
                board_pkg::RB_SYNC: begin
                    word_q <= board_pkg::ICAP_SYNC;
                    state_q <= board_pkg::RB_NOOP;
                end
                board_pkg::RB_NOOP: begin
                    word_q <= board_pkg::ICAP_NOOP;
                    state_q <= board_pkg::RB_CMD;
                end
                board_pkg::RB_CMD: begin
                    word_q <= board_pkg::ICAP_WRITE_CMD;
                    state_q <= board_pkg::RB_IPROG;
                end
                board_pkg::RB_IPROG: begin
                    word_q <= board_pkg::ICAP_IPROG;
                    state_q <= board_pkg::RB_TAIL;
                end
                board_pkg::RB_TAIL: begin
                    word_q <= board_pkg::ICAP_NOOP;
                    state_q <= board_pkg::RB_IDLE;
                end
                default: begin
                    word_q <= board_pkg::ICAP_DUMMY;
                    icap_csib_o <= 1'b1;
                    state_q <= board_pkg::RB_IDLE;
                end
            endcase
        end
    end

    // Configuration port takes each byte MSB-first on bit 0
    for (genvar b = 0; b < board_pkg::ICAP_W / 8; b++) begin : g_byte
        for (genvar i = 0; i < 8; i++) begin : g_bit
            assign icap_data_o[8*b + i] = word_q[8*b + 7 - i];
        end
    end

    assign icap_rdwrb_o = 1'b0;

    // Port stays selected through every non-idle state
    a_csib_state: assert property (
        @(posedge pcie_user_clk) disable iff (reset_i)
        (state_q != board_pkg::RB_IDLE) |-> !icap_csib_o
    ) else $error("csib high during a reboot sequence");

    // In idle, csib is low only while the tail word is still on the port
    a_csib_idle: assert property (
        @(posedge pcie_user_clk) disable iff (reset_i)
        (state_q == board_pkg::RB_IDLE && !icap_csib_o) |->
            ($past(state_q) == board_pkg::RB_TAIL)
    ) else $error("csib low in idle outside the tail word");

endmodule

// ==== verif/board_io_tb.sv ====
// Reads verif/board_io_vectors.txt from the project root; each V line is one clock cycle
`timescale 1ns/10ps

module board_io_tb;

    localparam int RESET_CYCLES = 10;
    localparam int MAX_VEC = 64;
    localparam int FIELDS = 24;
    localparam logic [31:0] IDLE_WORD = 32'hFFFF_FFFF;

    logic                                 pcie_user_clk;
    logic                                 reset_i;
    logic [board_pkg::I2C_LINE_COUNT-1:0]  i2c_drive_i;
    logic [board_pkg::I2C_LINE_COUNT-1:0]  i2c_release_i;
    logic [board_pkg::I2C_LINE_COUNT-1:0]  i2c_pin_i;
    logic [board_pkg::I2C_LINE_COUNT-1:0]  i2c_drive_o;
    logic [board_pkg::I2C_LINE_COUNT-1:0]  i2c_release_o;
    logic [board_pkg::I2C_LINE_COUNT-1:0]  i2c_sync_o;
    logic [board_pkg::FLASH_ADDR_W-1:0]    flash_addr_i;
    logic [board_pkg::FLASH_ADDR_W-1:0]    flash_addr_o;
    logic [board_pkg::FLASH_DQ_W-1:0]      flash_dq_i;
    logic [board_pkg::FLASH_DQ_W-1:0]      flash_dq_o;
    logic                                 flash_dq_oe_i;
    logic                                 flash_dq_oe_o;
    logic                                 flash_region_i;
    logic                                 flash_region_o;
    logic                                 flash_region_oe_i;
    logic                                 flash_region_oe_o;
    logic                                 flash_ce_n_i;
    logic                                 flash_oe_n_i;
    logic                                 flash_we_n_i;
    logic                                 flash_adv_n_i;
    logic                                 flash_ce_n_o;
    logic                                 flash_oe_n_o;
    logic                                 flash_we_n_o;
    logic                                 flash_adv_n_o;
    logic [board_pkg::FLASH_DQ_W-1:0]      flash_dq_pin_i;
    logic [board_pkg::FLASH_DQ_W-1:0]      flash_dq_sync_o;
    logic                                 fpga_boot_i;
    logic                                 icap_avail_i;
    logic                                 icap_csib_o;
    logic                                 icap_rdwrb_o;
    logic [board_pkg::ICAP_W-1:0]          icap_data_o;
    logic [board_pkg::STATUS_IN_COUNT-1:0] sfp_status_pin_i;
    logic [board_pkg::STATUS_IN_COUNT-1:0] sfp_status_sync_o;
    logic [board_pkg::SFP_COUNT-1:0]       sfp_rx_status_i;
    logic [board_pkg::SFP_COUNT-1:0]       sfp_led_o;

    // Fields 0..11 are inputs, 12..23 the outputs expected one falling edge later
    logic [31:0] vec [MAX_VEC][FIELDS];
    logic [31:0] reboot_words [6];
    int vec_count = 0;
    int word_count = 0;
    int boot_count = 0;
    int burst_idx = 0;
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    board_io_top #(
        .SYNC_STAGES(board_pkg::SYNC_STAGES)
    ) UUT (.*);

    initial begin
        pcie_user_clk = 1'b0;
        forever #2 pcie_user_clk = ~pcie_user_clk;
    end

    always @(posedge pcie_user_clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Simulation timed out after %0d cycles", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic load_vectors();
        int fd;
        int code;
        byte tag;
        logic [31:0] f [FIELDS];
        logic [31:0] word;
        logic [8*160-1:0] rest;
        fd = $fopen("verif/board_io_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/board_io_vectors.txt");
            error_count++;
        end else begin
            while ($fscanf(fd, " %c", tag) == 1) begin
                case (tag)
                    "#": code = $fgets(rest, fd);
                    "W": begin
                        code = $fscanf(fd, "%h", word);
                        if (word_count < 6) begin
                            reboot_words[word_count] = word;
                        end
                        word_count++;
                    end
                    "V": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5],
                            f[6], f[7], f[8], f[9], f[10], f[11]);
                        code += $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                            f[12], f[13], f[14], f[15], f[16], f[17],
                            f[18], f[19], f[20], f[21], f[22], f[23]);
                        if (code != FIELDS || vec_count >= MAX_VEC) begin
                            $display("Vector line %0d is malformed or too many", vec_count);
                            error_count++;
                        end else begin
                            for (int i = 0; i < FIELDS; i++) begin
                                vec[vec_count][i] = f[i];
                            end
                            if (f[10][0]) begin
                                boot_count++;
                            end
                            vec_count++;
                        end
                    end
                    default: begin
                        $display("Unknown line tag in vector file");
                        error_count++;
                    end
                endcase
            end
            $fclose(fd);
        end
        if (vec_count == 0 || word_count != 6) begin
            $display("Vector file holds %0d vectors and %0d reboot words", vec_count, word_count);
            error_count++;
        end
    endtask

    task automatic init_inputs();
        reset_i = 1'b1;
        {i2c_drive_i, i2c_release_i, i2c_pin_i} = '0;
        {flash_addr_i, flash_dq_i, flash_dq_pin_i} = '0;
        {flash_dq_oe_i, flash_region_i, flash_region_oe_i} = 3'b000;
        {flash_ce_n_i, flash_oe_n_i, flash_we_n_i, flash_adv_n_i} = 4'hF;
        {fpga_boot_i, icap_avail_i} = 2'b00;
        sfp_status_pin_i = '0;
        sfp_rx_status_i = '0;
    endtask

    task automatic drive_vector(input int k);
        sfp_status_pin_i = vec[k][0][board_pkg::STATUS_IN_COUNT-1:0];
        i2c_drive_i = vec[k][1][board_pkg::I2C_LINE_COUNT-1:0];
        i2c_release_i = vec[k][2][board_pkg::I2C_LINE_COUNT-1:0];
        i2c_pin_i = vec[k][3][board_pkg::I2C_LINE_COUNT-1:0];
        flash_addr_i = vec[k][4][board_pkg::FLASH_ADDR_W-1:0];
        flash_dq_i = vec[k][5][board_pkg::FLASH_DQ_W-1:0];
        {flash_dq_oe_i, flash_region_i, flash_region_oe_i} = vec[k][6][2:0];
        {flash_ce_n_i, flash_oe_n_i, flash_we_n_i, flash_adv_n_i} = vec[k][7][3:0];
        flash_dq_pin_i = vec[k][8][board_pkg::FLASH_DQ_W-1:0];
        sfp_rx_status_i = vec[k][9][board_pkg::SFP_COUNT-1:0];
        fpga_boot_i = vec[k][10][0];
        icap_avail_i = vec[k][11][0];
    endtask

    // Words of a burst follow the W list; outside a burst the port idles at all ones
    task automatic verify_icap_word();
        if (!icap_csib_o) begin
            if (burst_idx >= 6) begin
                $display("csib held low for more than six words at cycle %0d", cycle_count);
                error_count++;
            end else begin
                check_value("icap_data_o", icap_data_o, reboot_words[burst_idx]);
                burst_idx++;
            end
        end else begin
            if (burst_idx != 0 && burst_idx != 6) begin
                $display("Reboot sequence stopped after %0d words", burst_idx);
                error_count++;
            end
            burst_idx = 0;
            check_value("icap_data_o", icap_data_o, IDLE_WORD);
        end
    endtask

    task automatic compare_outputs(input int k);
        check_value("sfp_status_sync_o", 32'(sfp_status_sync_o), vec[k][12]);
        check_value("i2c_drive_o", 32'(i2c_drive_o), vec[k][13]);
        check_value("i2c_release_o", 32'(i2c_release_o), vec[k][14]);
        check_value("i2c_sync_o", 32'(i2c_sync_o), vec[k][15]);
        check_value("flash_addr_o", 32'(flash_addr_o), vec[k][16]);
        check_value("flash_dq_o", 32'(flash_dq_o), vec[k][17]);
        check_value("{flash_dq_oe_o,flash_region_o,flash_region_oe_o}",
            32'({flash_dq_oe_o, flash_region_o, flash_region_oe_o}), vec[k][18]);
        check_value("{flash_ce_n_o,flash_oe_n_o,flash_we_n_o,flash_adv_n_o}",
            32'({flash_ce_n_o, flash_oe_n_o, flash_we_n_o, flash_adv_n_o}), vec[k][19]);
        check_value("flash_dq_sync_o", 32'(flash_dq_sync_o), vec[k][20]);
        check_value("sfp_led_o", 32'(sfp_led_o), vec[k][21]);
        check_value("icap_csib_o", 32'(icap_csib_o), vec[k][22]);
        check_value("icap_rdwrb_o", 32'(icap_rdwrb_o), vec[k][23]);
        verify_icap_word();
    endtask

    task automatic verify_reset_state();
        check_value("i2c_release_o", 32'(i2c_release_o),
            32'({board_pkg::I2C_LINE_COUNT{1'b1}}));
        check_value("i2c_drive_o", 32'(i2c_drive_o), 32'({board_pkg::I2C_LINE_COUNT{1'b1}}));
        check_value("{flash_ce_n_o,flash_oe_n_o,flash_we_n_o,flash_adv_n_o}",
            32'({flash_ce_n_o, flash_oe_n_o, flash_we_n_o, flash_adv_n_o}), 32'hF);
        check_value("{flash_dq_oe_o,flash_region_o,flash_region_oe_o}",
            32'({flash_dq_oe_o, flash_region_o, flash_region_oe_o}), 32'h0);
        check_value("flash_addr_o", 32'(flash_addr_o), 32'h0);
        check_value("flash_dq_o", 32'(flash_dq_o), 32'h0);
        check_value("icap_csib_o", 32'(icap_csib_o), 32'h1);
        check_value("icap_data_o", icap_data_o, IDLE_WORD);
    endtask

    initial begin
        init_inputs();
        load_vectors();
        cycle_limit = vec_count + 6 * boot_count + RESET_CYCLES + 50;
        repeat (RESET_CYCLES) @(posedge pcie_user_clk);
        @(negedge pcie_user_clk);
        verify_reset_state();
        reset_i = 1'b0;
        if (vec_count > 0) begin
            drive_vector(0);
        end
        for (int k = 0; k < vec_count; k++) begin
            @(negedge pcie_user_clk);
            compare_outputs(k);
            if (k + 1 < vec_count) begin
                drive_vector(k + 1);
            end
        end
        $display("Checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/board_io_vectors.txt ====
# V in: stat drv rel pin addr dq fsel ctl dqpin rx boot avail, exp: same but led csib rdwrb
# fsel={dq_oe,region,region_oe} ctl={ce_n,oe_n,we_n,adv_n}; W: reversed ICAP words in order
W FFFFFFFF
W 5599AA66
W 04000000
W 0C000180
W 000000F0
W 04000000
V 3 1F 1F 1F 000000 0000 0 F FFFF 0 0 0  0 1F 1F 00 000000 0000 0 F 0000 0 1 0
V A 00 1E 15 123456 BEEF 5 4 1234 1 0 0  3 00 1E 1F 123456 BEEF 5 4 FFFF 1 1 0
V 5 0A 15 0A 7FFFFF 0001 3 2 A5A5 2 0 0  A 0A 15 15 7FFFFF 0001 3 2 1234 2 1 0
V F 1F 00 00 400001 8000 7 5 5A5A 3 0 0  5 1F 00 0A 400001 8000 7 5 A5A5 3 1 0
V 0 11 0E 1B 0F0F0F 55AA 2 3 0000 0 0 0  F 11 0E 00 0F0F0F 55AA 2 3 5A5A 0 1 0
V 9 04 1B 1F 2AAAAA FFFF 4 D FFFF 1 0 0  0 04 1B 1B 2AAAAA FFFF 4 D 0000 1 1 0
V 6 1F 1F 04 000010 0F0F 0 F 8001 2 1 0  9 1F 1F 1F 000010 0F0F 0 F FFFF 2 1 0
V C 1F 1F 1F 000020 F0F0 0 F 7FFE 3 1 0  6 1F 1F 04 000020 F0F0 0 F 8001 3 1 0
V 1 1F 1F 1F 000030 1111 0 F 0101 1 1 1  C 1F 1F 1F 000030 1111 0 F 7FFE 1 0 0
V 2 1F 1F 1E 000040 2222 1 E 0202 0 1 1  1 1F 1F 1F 000040 2222 1 E 0101 0 0 0
V 4 1F 1F 1D 000050 3333 0 F 0303 2 1 1  2 1F 1F 1E 000050 3333 0 F 0202 2 0 0
V 8 1F 1F 1B 000060 4444 0 F 0404 3 1 1  4 1F 1F 1D 000060 4444 0 F 0303 3 0 0
V 7 1F 1F 17 000070 5555 0 F 0505 1 1 1  8 1F 1F 1B 000070 5555 0 F 0404 1 0 0
V B 1F 1F 0F 000080 6666 0 F 0606 0 1 1  7 1F 1F 17 000080 6666 0 F 0505 0 0 0
V D 1F 1F 1F 000090 7777 0 F 0707 2 1 1  B 1F 1F 0F 000090 7777 0 F 0606 2 1 0
V E 1F 1F 1F 0000A0 8888 0 F 0808 3 1 1  D 1F 1F 1F 0000A0 8888 0 F 0707 3 0 0
V 0 1F 1F 1F 0000B0 9999 0 F 0909 1 1 1  E 1F 1F 1F 0000B0 9999 0 F 0808 1 0 0
V 3 1F 1F 1F 0000C0 AAAA 0 F 0A0A 0 1 1  0 1F 1F 1F 0000C0 AAAA 0 F 0909 0 0 0
V 5 1F 1F 1F 0000D0 BBBB 0 F 0B0B 2 1 1  3 1F 1F 1F 0000D0 BBBB 0 F 0A0A 2 0 0
V A 1F 1F 1F 0000E0 CCCC 0 F 0C0C 3 0 0  5 1F 1F 1F 0000E0 CCCC 0 F 0B0B 3 0 0
V F 1F 1F 1F 0000F0 DDDD 0 F 0D0D 1 0 0  A 1F 1F 1F 0000F0 DDDD 0 F 0C0C 1 0 0
V 0 1F 1F 1F 000100 EEEE 0 F 0E0E 0 0 0  F 1F 1F 1F 000100 EEEE 0 F 0D0D 0 1 0
V 0 1F 1F 1F 000000 0000 0 F 0F0F 0 0 1  0 1F 1F 1F 000000 0000 0 F 0E0E 0 1 0
V 0 1F 1F 1F 000000 0000 0 F 0000 0 0 0  0 1F 1F 1F 000000 0000 0 F 0F0F 0 1 0
